/* id_params.svh */
// rv64 widths with 32-bit instructions and three pipeline stages behind decode
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// data path and pc
`define XLEN 64

// fetched instruction word
`define INST_W 32

// general registers
`define GPR_ADDR_W 5
`define GPR_COUNT 32

// execute, memory and write-back
`define LATER_STAGES 3

// a0 carries the ebreak result code
`define EBREAK_SRC_REG 10

`endif

/* id_pkg.sv */
// shared decode stage types, sized by id_params.svh and matched to the bus layouts of fetch and execute
`default_nettype none

`include "id_params.svh"

package id_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`INST_W-1:0] inst_t;
  typedef logic [`GPR_ADDR_W-1:0] gpr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  // same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  typedef struct packed {
    inst_t inst;
    xlen_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xlen_t     wdata;
  } rf_wr_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } br_t;

  typedef struct packed {
    gpr_addr_t  rs1;
    gpr_addr_t  rs2;
    gpr_addr_t  rd;
    logic       uses_rs1;
    logic       uses_rs2;
    xlen_t      imm;          // sign extended
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic [2:0] br_func;
    logic       alu_src1_pc;
    logic       alu_src2_imm;
    logic       alu_word;     // 32-bit op, result sign extended
    alu_op_e    alu_op;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_op_e    mem_op;
    logic       ebreak;
    logic       invalid;
  } decode_t;

  typedef struct packed {
    xlen_t     rs1data;
    xlen_t     rs2data;
    xlen_t     imm;
    xlen_t     pc;
    logic      alu_src1_pc;
    logic      alu_src2_imm;
    logic      alu_word;
    alu_op_e   alu_op;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_e   mem_op;
    logic      ebreak;
    logic      invalid;
  } ds_to_es_t;

endpackage

`default_nettype wire

/* id_decoder.sv */
// decodes the rv64i subset with ebreak only from system, anything else comes out invalid
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module id_decoder (
  input  id_pkg::inst_t   i_inst,
  output id_pkg::decode_t o_dec
);

  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
  localparam id_pkg::inst_t INST_EBREAK = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  id_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
  logic r_f7_ok;     // funct7 legal for op / op-32
  logic w_f3_ok;     // funct3 exists in the 32-bit groups
  logic shamt6_ok;   // op-imm shifts take a 6-bit shamt

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  assign r_f7_ok = (funct7 == 7'b0) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign w_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
  assign shamt6_ok = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b0) :
                     (funct3 == 3'b101) ? (i_inst[31:26] == 6'b0 ||
                                           i_inst[31:26] == 6'b010000) : 1'b1;

  function automatic id_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_op_of = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  alu_op_of = id_pkg::ALU_SLL;
      3'b010:  alu_op_of = id_pkg::ALU_SLT;
      3'b011:  alu_op_of = id_pkg::ALU_SLTU;
      3'b100:  alu_op_of = id_pkg::ALU_XOR;
      3'b101:  alu_op_of = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  alu_op_of = id_pkg::ALU_OR;
      default: alu_op_of = id_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_dec          = '0;
    o_dec.rs1      = i_inst[19:15];
    o_dec.rs2      = i_inst[24:20];
    o_dec.rd       = i_inst[11:7];
    o_dec.br_func  = funct3;
    o_dec.alu_op   = id_pkg::ALU_ADD;
    o_dec.mem_op   = id_pkg::mem_op_e'(funct3);
    case (opcode)
      OPC_LUI: begin
        o_dec.imm          = imm_u;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.alu_op       = id_pkg::ALU_PASS_B;
        o_dec.gpr_wen      = 1'b1;
      end
      OPC_AUIPC: begin
        o_dec.imm          = imm_u;
        o_dec.alu_src1_pc  = 1'b1;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin  // link is pc + 4
        o_dec.imm          = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_dec.is_jal       = (opcode == OPC_JAL);
        o_dec.is_jalr      = (opcode == OPC_JALR);
        o_dec.uses_rs1     = (opcode == OPC_JALR);
        o_dec.alu_src1_pc  = 1'b1;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
        o_dec.invalid      = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_dec.imm       = imm_b;
        o_dec.is_branch = 1'b1;
        o_dec.uses_rs1  = 1'b1;
        o_dec.uses_rs2  = 1'b1;
        o_dec.invalid   = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD, OPC_STORE: begin
        o_dec.imm          = (opcode == OPC_LOAD) ? imm_i : imm_s;
        o_dec.uses_rs1     = 1'b1;
        o_dec.uses_rs2     = (opcode == OPC_STORE);
        o_dec.alu_src2_imm = 1'b1;
        o_dec.mem_ren      = (opcode == OPC_LOAD);
        o_dec.mem_wen      = (opcode == OPC_STORE);
        o_dec.gpr_wen      = (opcode == OPC_LOAD);
        o_dec.invalid      = (opcode == OPC_LOAD) ? (funct3 == 3'b111) : funct3[2];
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        o_dec.imm          = imm_i;
        o_dec.uses_rs1     = 1'b1;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
        o_dec.alu_word     = (opcode == OPC_OP_IMM_32);
        o_dec.alu_op       = alu_op_of(funct3, i_inst[30] && funct3 == 3'b101);
        if (opcode == OPC_OP_IMM) begin
          o_dec.invalid = !shamt6_ok;
        end else begin
          o_dec.invalid = !w_f3_ok || (funct3 != 3'b000 && !r_f7_ok);
        end
      end
      OPC_OP, OPC_OP_32: begin
        o_dec.uses_rs1 = 1'b1;
        o_dec.uses_rs2 = 1'b1;
        o_dec.gpr_wen  = 1'b1;
        o_dec.alu_word = (opcode == OPC_OP_32);
        o_dec.alu_op   = alu_op_of(funct3, funct7[5]);
        o_dec.invalid  = !r_f7_ok || (opcode == OPC_OP_32 && !w_f3_ok);
      end
      OPC_SYSTEM: begin
        if (i_inst == INST_EBREAK) begin
          o_dec.ebreak   = 1'b1;
          o_dec.rs1      = id_pkg::gpr_addr_t'(`EBREAK_SRC_REG);
          o_dec.uses_rs1 = 1'b1;
        end else begin
          o_dec.invalid = 1'b1;
        end
      end
      default: o_dec.invalid = 1'b1;
    endcase
    // invalid encodings must not write, redirect or stall
    if (o_dec.invalid) begin
      o_dec.uses_rs1  = 1'b0;
      o_dec.uses_rs2  = 1'b0;
      o_dec.is_branch = 1'b0;
      o_dec.is_jal    = 1'b0;
      o_dec.is_jalr   = 1'b0;
      o_dec.gpr_wen   = 1'b0;
      o_dec.mem_ren   = 1'b0;
      o_dec.mem_wen   = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* id_hazard_match.sv */
// one later stage only, a destination of x0 never counts as a pending write
`timescale 1ns/1ps
`default_nettype none

module id_hazard_match (
  input  id_pkg::gpr_addr_t i_dest,
  input  id_pkg::decode_t   i_dec,
  output logic              o_hit
);

  logic dest_pending;
  logic rs1_hit;
  logic rs2_hit;

  assign dest_pending = (i_dest != '0);

  // only sources the instruction really reads
  assign rs1_hit = i_dec.uses_rs1 && (i_dest == i_dec.rs1);
  assign rs2_hit = i_dec.uses_rs2 && (i_dest == i_dec.rs2);

  assign o_hit = dest_pending && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

/* id_branch_unit.sv */
// raw branch and jump resolution, the result is not yet qualified by stage valid or stall
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit (
  input  id_pkg::decode_t i_dec,
  input  id_pkg::xlen_t   i_pc,
  input  id_pkg::xlen_t   i_rs1data,
  input  id_pkg::xlen_t   i_rs2data,
  output id_pkg::br_t     o_br
);

  id_pkg::xlen_t pc_target;
  id_pkg::xlen_t reg_target;
  logic          eq;
  logic          lt;
  logic          ltu;
  logic          cond;

  assign pc_target  = i_pc + i_dec.imm;
  assign reg_target = (i_rs1data + i_dec.imm) & ~id_pkg::xlen_t'(1);  // jalr drops bit 0

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_dec.br_func)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;
      3'b101:  cond = !lt;
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;  // not a branch encoding
    endcase
  end

  always_comb begin
    o_br.taken  = 1'b0;
    o_br.target = pc_target;
    if (i_dec.is_jal) begin
      o_br.taken = 1'b1;
    end else if (i_dec.is_jalr) begin
      o_br.taken  = 1'b1;
      o_br.target = reg_target;
    end else if (i_dec.is_branch) begin
      o_br.taken = cond;
    end
  end

endmodule

`default_nettype wire

/* id_gpr_file.sv */
// reads are combinational with no write bypass, so a same-cycle write shows only next cycle
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  id_pkg::gpr_addr_t i_raddr1,
  output id_pkg::xlen_t     o_rdata1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xlen_t     o_rdata2,
  input  id_pkg::rf_wr_t    i_wr
);

  id_pkg::xlen_t regs [1:`GPR_COUNT-1];  // x0 is not stored

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < `GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

/* id_stage_ctrl.sv */
// the redirect stays up while execute back-pressures, so fetch must hold its offer until taken
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module id_stage_ctrl (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_fs_valid,
  input  id_pkg::fs_to_ds_t        i_fs_bus,
  output logic                     o_ds_allowin,
  input  logic                     i_es_allowin,
  input  logic [`LATER_STAGES-1:0] i_hits,
  input  id_pkg::br_t              i_br_raw,
  output id_pkg::br_t              o_br,
  output logic                     o_ds_valid_go,
  output id_pkg::fs_to_ds_t        o_inst_bus
);

  logic              ds_valid;
  logic              ready_go;
  logic              fs_accept;
  logic              br_taken;
  logic              br_squash;
  id_pkg::fs_to_ds_t inst_bus_r;

  assign ready_go      = ~|i_hits;  // wait out pending writes
  assign o_ds_allowin  = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_valid_go = ds_valid && ready_go;
  assign fs_accept     = i_fs_valid && o_ds_allowin;

  // redirect only from a live instruction with its operands ready
  assign br_taken = o_ds_valid_go && i_br_raw.taken;
  assign o_br     = '{taken: br_taken, target: i_br_raw.target};

  // wrong-path fetch
  assign br_squash = br_taken && (i_fs_bus.pc != i_br_raw.target);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid && !br_squash;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fs_accept) begin
      inst_bus_r <= i_fs_bus;
    end
  end

  assign o_inst_bus = inst_bus_r;

endmodule

`default_nettype wire

/* id_stage.sv */
// decode stage top, later stages report pending writes by rd with zero meaning none
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module id_stage (
  input  logic                                       i_clk,
  input  logic                                       i_arst_n,
  input  logic                                       i_fs_valid,
  input  id_pkg::fs_to_ds_t                          i_fs_bus,
  output logic                                       o_ds_allowin,
  input  logic                                       i_es_allowin,
  output logic                                       o_es_valid,
  output id_pkg::ds_to_es_t                          o_es_bus,
  output id_pkg::br_t                                o_br,
  input  id_pkg::rf_wr_t                             i_rf_wr,
  input  id_pkg::gpr_addr_t [`LATER_STAGES-1:0]      i_later_rd  // es, ms, ws
);

  id_pkg::fs_to_ds_t        inst_bus;
  id_pkg::decode_t          dec;
  id_pkg::xlen_t            rs1data;
  id_pkg::xlen_t            rs2data;
  id_pkg::br_t              br_raw;
  logic [`LATER_STAGES-1:0] hits;

  id_stage_ctrl id_stage_ctrl_inst (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_fs_valid    (i_fs_valid),
    .i_fs_bus      (i_fs_bus),
    .o_ds_allowin  (o_ds_allowin),
    .i_es_allowin  (i_es_allowin),
    .i_hits        (hits),
    .i_br_raw      (br_raw),
    .o_br          (o_br),
    .o_ds_valid_go (o_es_valid),
    .o_inst_bus    (inst_bus)
  );

  id_decoder id_decoder_inst (
    .i_inst (inst_bus.inst),
    .o_dec  (dec)
  );

  id_gpr_file id_gpr_file_inst (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (dec.rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (dec.rs2),
    .o_rdata2 (rs2data),
    .i_wr     (i_rf_wr)
  );

  id_branch_unit id_branch_unit_inst (
    .i_dec     (dec),
    .i_pc      (inst_bus.pc),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .o_br      (br_raw)
  );

  genvar k;
  generate
    for (k = 0; k < `LATER_STAGES; k++) begin : g_hazard
      id_hazard_match id_hazard_match_inst (
        .i_dest (i_later_rd[k]),
        .i_dec  (dec),
        .o_hit  (hits[k])
      );
    end
  endgenerate

  // jumps hand execute the link offset instead of the target offset
  assign o_es_bus = '{
    rs1data:      rs1data,
    rs2data:      rs2data,
    imm:          (dec.is_jal || dec.is_jalr) ? id_pkg::xlen_t'(4) : dec.imm,
    pc:           inst_bus.pc,
    alu_src1_pc:  dec.alu_src1_pc,
    alu_src2_imm: dec.alu_src2_imm,
    alu_word:     dec.alu_word,
    alu_op:       dec.alu_op,
    rd:           dec.rd,
    gpr_wen:      dec.gpr_wen,
    mem_ren:      dec.mem_ren,
    mem_wen:      dec.mem_wen,
    mem_op:       dec.mem_op,
    ebreak:       dec.ebreak,
    invalid:      dec.invalid
  };

endmodule

`default_nettype wire

/* tb_id_stage.sv */
// directed tests only, register writes come from the testbench, the stage payload has no reset
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module tb_id_stage;

  localparam int CLK_PERIOD      = 40;
  localparam int ISSUE_WAIT      = 20;  // cycles before an offer counts as lost
  localparam int TEST_COUNT      = 6;
  localparam int TEST_BUDGET     = 40;
  localparam int WATCHDOG_CYCLES = TEST_COUNT * TEST_BUDGET + 20;

  logic                                  i_clk;
  logic                                  i_arst_n;
  logic                                  i_fs_valid;
  id_pkg::fs_to_ds_t                     i_fs_bus;
  logic                                  o_ds_allowin;
  logic                                  i_es_allowin;
  logic                                  o_es_valid;
  id_pkg::ds_to_es_t                     o_es_bus;
  id_pkg::br_t                           o_br;
  id_pkg::rf_wr_t                        i_rf_wr;
  id_pkg::gpr_addr_t [`LATER_STAGES-1:0] i_later_rd;

  id_pkg::xlen_t     model_regs [0:`GPR_COUNT-1];
  id_pkg::ds_to_es_t exp_bus;
  id_pkg::inst_t     inst;
  int                checks;
  int                errors;
  int                test_errors;
  int unsigned       seed_val;

  id_stage id_stage_inst (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_bus     (i_fs_bus),
    .o_ds_allowin (o_ds_allowin),
    .i_es_allowin (i_es_allowin),
    .o_es_valid   (o_es_valid),
    .o_es_bus     (o_es_bus),
    .o_br         (o_br),
    .i_rf_wr      (i_rf_wr),
    .i_later_rd   (i_later_rd)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  function automatic id_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
    enc_r = {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic id_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic id_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic id_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // fields every instruction carries straight from its encoding
  function automatic id_pkg::ds_to_es_t base_exp(input id_pkg::inst_t in, input id_pkg::xlen_t pc);
    id_pkg::ds_to_es_t e;
    e         = '0;
    e.rs1data = model_regs[in[19:15]];
    e.rs2data = model_regs[in[24:20]];
    e.pc      = pc;
    e.rd      = in[11:7];
    e.alu_op  = id_pkg::ALU_ADD;
    e.mem_op  = id_pkg::mem_op_e'(in[14:12]);
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    compare_value(name, 64'(exp), 64'(act));
  endtask

  task automatic check_xlen(input string name, input id_pkg::xlen_t exp, input id_pkg::xlen_t act);
    compare_value(name, exp, act);
  endtask

  task automatic check_br(input id_pkg::br_t exp, input id_pkg::br_t act);
    check_bit("o_br.taken", exp.taken, act.taken);
    check_xlen("o_br.target", exp.target, act.target);
  endtask

  task automatic check_es_bus(input id_pkg::ds_to_es_t exp, input id_pkg::ds_to_es_t act);
    check_xlen("o_es_bus.rs1data", exp.rs1data, act.rs1data);
    check_xlen("o_es_bus.rs2data", exp.rs2data, act.rs2data);
    check_xlen("o_es_bus.imm", exp.imm, act.imm);
    check_xlen("o_es_bus.pc", exp.pc, act.pc);
    check_bit("o_es_bus.alu_src1_pc", exp.alu_src1_pc, act.alu_src1_pc);
    check_bit("o_es_bus.alu_src2_imm", exp.alu_src2_imm, act.alu_src2_imm);
    check_bit("o_es_bus.alu_word", exp.alu_word, act.alu_word);
    compare_value("o_es_bus.alu_op", 64'(exp.alu_op), 64'(act.alu_op));
    compare_value("o_es_bus.rd", 64'(exp.rd), 64'(act.rd));
    check_bit("o_es_bus.gpr_wen", exp.gpr_wen, act.gpr_wen);
    check_bit("o_es_bus.mem_ren", exp.mem_ren, act.mem_ren);
    check_bit("o_es_bus.mem_wen", exp.mem_wen, act.mem_wen);
    compare_value("o_es_bus.mem_op", 64'(exp.mem_op), 64'(act.mem_op));
    check_bit("o_es_bus.ebreak", exp.ebreak, act.ebreak);
    check_bit("o_es_bus.invalid", exp.invalid, act.invalid);
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #2;
  endtask

  task automatic write_reg(input id_pkg::gpr_addr_t addr, input id_pkg::xlen_t data);
    i_rf_wr = '{wen: 1'b1, waddr: addr, wdata: data};
    next_cycle();
    i_rf_wr = '0;
    if (addr != '0) model_regs[addr] = data;
  endtask

  // offer one instruction and return in the cycle after the accepting edge
  task automatic issue(input id_pkg::xlen_t pc, input id_pkg::inst_t in);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    i_fs_valid = 1'b1;
    i_fs_bus   = '{inst: in, pc: pc};
    while (!taken && waited < ISSUE_WAIT) begin
      #1;
      taken = o_ds_allowin;
      @(posedge i_clk);
      #2;
      waited++;
    end
    i_fs_valid = 1'b0;
    if (!taken) begin
      errors++;
      $display("instruction at pc %0h was never accepted by the stage", pc);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic issue_and_check(input id_pkg::xlen_t pc, input id_pkg::ds_to_es_t exp);
    issue(pc, inst);
    #1;
    check_bit("o_es_valid", 1'b1, o_es_valid);
    check_es_bus(exp, o_es_bus);
    next_cycle();
  endtask

  task automatic test_reset();
    #1;
    check_bit("o_es_valid", 1'b0, o_es_valid);
    check_bit("o_br.taken", 1'b0, o_br.taken);
    check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
    next_cycle();
    finish_test("reset");
  endtask

  task automatic test_reg_read();
    write_reg(5'd1, {$urandom, $urandom});
    write_reg(5'd2, {$urandom, $urandom});
    write_reg(5'd10, {$urandom, $urandom});
    inst = enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011);  // add x3, x1, x2
    exp_bus = base_exp(inst, 64'h100);
    exp_bus.gpr_wen = 1'b1;
    issue_and_check(64'h100, exp_bus);
    inst = enc_r(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd4, 7'b0111011);  // subw x4, x2, x1
    exp_bus = base_exp(inst, 64'h104);
    exp_bus.gpr_wen  = 1'b1;
    exp_bus.alu_word = 1'b1;
    exp_bus.alu_op   = id_pkg::ALU_SUB;
    issue_and_check(64'h104, exp_bus);
    inst = enc_r(7'b0, 5'd2, 5'd0, 3'b000, 5'd5, 7'b0110011);  // add x5, x0, x2
    exp_bus = base_exp(inst, 64'h108);
    exp_bus.rs1data = '0;
    exp_bus.gpr_wen = 1'b1;
    issue_and_check(64'h108, exp_bus);
    finish_test("register read and r-type");
  endtask

  task automatic test_imm_mem();
    inst = enc_i(-12'sd5, 5'd1, 3'b000, 5'd6, 7'b0010011);  // addi x6, x1, -5
    exp_bus = base_exp(inst, 64'h200);
    exp_bus.imm          = -64'sd5;
    exp_bus.alu_src2_imm = 1'b1;
    exp_bus.gpr_wen      = 1'b1;
    issue_and_check(64'h200, exp_bus);
    inst = {20'h80000, 5'd7, 7'b0110111};  // lui x7
    exp_bus = base_exp(inst, 64'h204);
    exp_bus.imm          = 64'hffff_ffff_8000_0000;
    exp_bus.alu_src2_imm = 1'b1;
    exp_bus.alu_op       = id_pkg::ALU_PASS_B;
    exp_bus.gpr_wen      = 1'b1;
    issue_and_check(64'h204, exp_bus);
    inst = enc_i(12'd16, 5'd1, 3'b011, 5'd8, 7'b0000011);  // ld x8, 16(x1)
    exp_bus = base_exp(inst, 64'h208);
    exp_bus.imm          = 64'd16;
    exp_bus.alu_src2_imm = 1'b1;
    exp_bus.gpr_wen      = 1'b1;
    exp_bus.mem_ren      = 1'b1;
    issue_and_check(64'h208, exp_bus);
    inst = enc_s(-12'sd8, 5'd2, 5'd1, 3'b011);  // sd x2, -8(x1)
    exp_bus = base_exp(inst, 64'h20c);
    exp_bus.imm          = -64'sd8;
    exp_bus.alu_src2_imm = 1'b1;
    exp_bus.mem_wen      = 1'b1;
    issue_and_check(64'h20c, exp_bus);
    issue(64'h210, 32'h0000_000b);  // custom-0, not in the subset
    #1;
    check_bit("o_es_bus.invalid", 1'b1, o_es_bus.invalid);
    check_bit("o_es_bus.gpr_wen", 1'b0, o_es_bus.gpr_wen);
    next_cycle();
    finish_test("immediate and memory decode");
  endtask

  task automatic stall_release(input int stage, input id_pkg::gpr_addr_t dest,
                               input id_pkg::xlen_t pc);
    i_later_rd[stage] = dest;
    issue(pc, inst);
    repeat (3) begin
      #1;
      check_bit("o_es_valid", 1'b0, o_es_valid);
      check_bit("o_ds_allowin", 1'b0, o_ds_allowin);
      next_cycle();
    end
    i_later_rd = '0;
    #1;
    check_bit("o_es_valid", 1'b1, o_es_valid);
    check_es_bus(exp_bus, o_es_bus);
    next_cycle();
  endtask

  task automatic test_hazard();
    inst = enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011);
    exp_bus = base_exp(inst, 64'h300);
    exp_bus.gpr_wen = 1'b1;
    stall_release(1, 5'd1, 64'h300);
    inst = enc_r(7'b0, 5'd2, 5'd0, 3'b000, 5'd3, 7'b0110011);  // x0 source, rd 0 pending
    exp_bus = base_exp(inst, 64'h304);
    exp_bus.rs1data = '0;
    exp_bus.gpr_wen = 1'b1;
    i_later_rd[0] = 5'd0;
    issue_and_check(64'h304, exp_bus);
    inst = enc_i(-12'sd5, 5'd1, 3'b000, 5'd6, 7'b0010011);  // rs2 field 27 is unused
    exp_bus = base_exp(inst, 64'h308);
    exp_bus.imm          = -64'sd5;
    exp_bus.alu_src2_imm = 1'b1;
    exp_bus.gpr_wen      = 1'b1;
    i_later_rd[2] = 5'd27;
    issue_and_check(64'h308, exp_bus);
    i_later_rd = '0;
    inst = 32'h0010_0073;  // ebreak reads a0
    exp_bus = base_exp(inst, 64'h30c);
    exp_bus.rs1data = model_regs[`EBREAK_SRC_REG];
    exp_bus.ebreak  = 1'b1;
    stall_release(0, 5'd10, 64'h30c);
    finish_test("hazard stall");
  endtask

  task automatic test_branch();
    logic [11:0] jalr_imm;
    jalr_imm = model_regs[2][0] ? 12'd4 : 12'd5;  // keeps x2 plus imm odd
    issue(64'h1000, enc_b(13'd32, 5'd1, 5'd1, 3'b000));  // beq x1, x1, +32
    i_fs_valid = 1'b1;  // wrong-path fetch
    i_fs_bus   = '{inst: enc_i(12'd1, 5'd0, 3'b000, 5'd9, 7'b0010011), pc: 64'h1004};
    #1;
    check_br('{taken: 1'b1, target: 64'h1020}, o_br);
    check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
    next_cycle();
    i_fs_valid = 1'b0;
    #1;
    check_bit("o_es_valid", 1'b0, o_es_valid);
    next_cycle();
    issue(64'h2000, enc_b(13'd32, 5'd1, 5'd1, 3'b001));  // bne x1, x1
    #1;
    check_bit("o_br.taken", 1'b0, o_br.taken);
    check_bit("o_es_valid", 1'b1, o_es_valid);
    next_cycle();
    issue(64'h3000, enc_i(jalr_imm, 5'd2, 3'b000, 5'd0, 7'b1100111));  // jalr x0, imm(x2)
    #1;
    // odd sum, the target is one below it
    check_br('{taken: 1'b1, target: model_regs[2] + 64'(jalr_imm) - 64'd1}, o_br);
    next_cycle();
    finish_test("branch redirect");
  endtask

  task automatic test_backpressure();
    i_es_allowin = 1'b0;
    inst = enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011);
    exp_bus = base_exp(inst, 64'h400);
    exp_bus.gpr_wen = 1'b1;
    issue(64'h400, inst);
    i_fs_valid = 1'b1;
    inst = enc_r(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd4, 7'b0111011);
    i_fs_bus = '{inst: inst, pc: 64'h404};
    repeat (4) begin
      #1;
      check_bit("o_es_valid", 1'b1, o_es_valid);
      check_bit("o_ds_allowin", 1'b0, o_ds_allowin);
      check_es_bus(exp_bus, o_es_bus);
      next_cycle();
    end
    i_es_allowin = 1'b1;
    #1;
    check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
    next_cycle();
    i_fs_valid = 1'b0;
    exp_bus = base_exp(inst, 64'h404);
    exp_bus.gpr_wen  = 1'b1;
    exp_bus.alu_word = 1'b1;
    exp_bus.alu_op   = id_pkg::ALU_SUB;
    #1;
    check_bit("o_es_valid", 1'b1, o_es_valid);
    check_es_bus(exp_bus, o_es_bus);
    next_cycle();
    finish_test("back-pressure");
  endtask

  initial begin
    seed_val     = $urandom(32'h0d88_3b20);
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    i_arst_n     = 1'b0;
    i_fs_valid   = 1'b0;
    i_fs_bus     = '0;
    i_es_allowin = 1'b1;
    i_rf_wr      = '0;
    i_later_rd   = '0;
    for (int i = 0; i < `GPR_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge i_clk);
    #2;
    i_arst_n = 1'b1;
    test_reset();
    test_reg_read();
    test_imm_mem();
    test_hazard();
    test_branch();
    test_backpressure();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
id_pkg.sv
id_decoder.sv
id_hazard_match.sv
id_branch_unit.sv
id_gpr_file.sv
id_stage_ctrl.sv
id_stage.sv
tb_id_stage.sv
